//--- logic/board_cfg_pkg.sv
// Board setting types, settings register map and fan PWM constants
package board_cfg_pkg;

  // Boot mode as seen by the SoC
  typedef logic [1:0] boot_mode_t;

  // Fan duty in sixteenths of a PWM period
  typedef logic [3:0] fan_duty_t;

  typedef logic [3:0] reg_addr_t;

  // Software boot override, same layout as REG_BOOT_OVR
  typedef struct packed {
    logic       en;
    boot_mode_t mode;
  } boot_ovr_t;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  localparam reg_addr_t REG_FAN_DUTY = 4'd0;
  localparam reg_addr_t REG_BOOT_OVR = 4'd1;
  localparam reg_addr_t REG_BOOT_EFF = 4'd2;  // read only
  localparam reg_addr_t REG_SCRATCH  = 4'd3;

  // Fan PWM period in soc_clk cycles
  localparam int unsigned PwmSteps = 32'd16;

endpackage

//--- logic/host_link_pkg.sv
// Host link opcodes, status codes, command word views, decoded command and result
package host_link_pkg;

  typedef enum logic [3:0] {
    OP_NOP   = 4'h0,
    OP_WRITE = 4'h1,
    OP_READ  = 4'h2
  } opcode_t;

  typedef enum logic [1:0] {
    ST_OK       = 2'd0,
    ST_BAD_ADDR = 2'd1,
    ST_BAD_OP   = 2'd2
  } status_t;

  // Write view, tag in the low byte
  typedef struct packed {
    logic [3:0]               opcode;
    board_cfg_pkg::reg_addr_t addr;
    logic [15:0]              data;
    logic [7:0]               tag;
  } cmd_wr_t;

  // Read view, tag right below the address
  typedef struct packed {
    logic [3:0]               opcode;
    board_cfg_pkg::reg_addr_t addr;
    logic [7:0]               tag;
    logic [15:0]              pad;
  } cmd_rd_t;

  // Opcode and address share bits in both views
  typedef union packed {
    cmd_wr_t wr;
    cmd_rd_t rd;
  } cmd_word_u;

  typedef struct packed {
    opcode_t                  op;
    board_cfg_pkg::reg_addr_t addr;
    logic [7:0]               tag;
    logic [15:0]              data;
    logic                     illegal;
  } dec_cmd_t;

  typedef struct packed {
    status_t     status;
    logic [7:0]  tag;
    logic [15:0] data;
  } rsp_t;

endpackage

//--- logic/clock_reset_unit.sv
// Reset combining and synchronizer, test mode bypass and RTC clock divider
`timescale 1ns/1ps

module clock_reset_unit #(
  parameter int unsigned RtcDiv = 50
) (
  input  logic soc_clk,
  input  logic sys_rst_ni,
  input  logic sw_rst_i,
  input  logic test_mode_i,
  output logic rst_no,
  output logic rtc_o
);

  localparam int unsigned RtcHalf = RtcDiv / 2;
  localparam int unsigned CntW    = (RtcHalf > 1) ? $clog2(RtcHalf) : 1;

  ////////////////////////////////////////
  // Reset synchronizer
  ////////////////////////////////////////

  logic [1:0] sync_q;

  // Board reset asserts at once, software pulse clears on the edge
  always_ff @(posedge soc_clk or negedge sys_rst_ni) begin
    if (!sys_rst_ni) begin
      sync_q <= 2'b00;
    end else if (sw_rst_i) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  // Scan test drives the board pin straight through
  assign rst_no = test_mode_i ? sys_rst_ni : sync_q[1];

  ////////////////////////////////////////
  // RTC divider
  ////////////////////////////////////////

  logic [CntW-1:0] rtc_cnt_q;
  logic            rtc_q;

  // Toggle every half period
  always_ff @(posedge soc_clk or negedge rst_no) begin
    if (!rst_no) begin
      rtc_cnt_q <= '0;
      rtc_q     <= 1'b0;
    end else if (rtc_cnt_q == CntW'(RtcHalf - 1)) begin
      rtc_cnt_q <= '0;
      rtc_q     <= ~rtc_q;
    end else begin
      rtc_cnt_q <= rtc_cnt_q + CntW'(1);
    end
  end

  assign rtc_o = rtc_q;

  assert property (@(posedge soc_clk) (RtcDiv % 2 == 0) && (RtcDiv >= 2))
    else $error("clock_reset_unit: RtcDiv must be even and at least 2");

endmodule

//--- logic/cmd_decode.sv
// Command FIFO with credit return and decode of the command word views
`timescale 1ns/1ps

module cmd_decode #(
  parameter int unsigned CmdDepth = 4
) (
  input  logic                     soc_clk,
  input  logic                     rst_n,
  input  logic                     cmd_valid_i,
  input  host_link_pkg::cmd_word_u cmd_i,
  output logic                     cmd_credit_o,
  input  logic                     exe_ready_i,
  output logic                     dec_valid_o,
  output host_link_pkg::dec_cmd_t  dec_cmd_o
);

  localparam int unsigned PtrW = (CmdDepth > 1) ? $clog2(CmdDepth) : 1;
  localparam int unsigned CntW = $clog2(CmdDepth + 1);

  host_link_pkg::cmd_word_u mem_q [CmdDepth];
  host_link_pkg::cmd_word_u head;
  logic [PtrW-1:0]          wr_ptr_q;
  logic [PtrW-1:0]          rd_ptr_q;
  logic [CntW-1:0]          count_q;
  logic                     full;
  logic                     push;
  logic                     pop;

  ////////////////////////////////////////
  // Command FIFO
  ////////////////////////////////////////

  assign full = (count_q == CntW'(CmdDepth));
  assign push = cmd_valid_i && !full;
  assign pop  = (count_q != '0) && exe_ready_i;

  always_ff @(posedge soc_clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= cmd_i;
    end
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(CmdDepth - 1)) ? '0 : wr_ptr_q + PtrW'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(CmdDepth - 1)) ? '0 : rd_ptr_q + PtrW'(1);
      end
      count_q <= count_q + CntW'(push) - CntW'(pop);
    end
  end

  // Each pop frees one slot and hands the host one credit
  assign cmd_credit_o = pop;
  assign dec_valid_o  = pop;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  assign head = mem_q[rd_ptr_q];

  always_comb begin
    dec_cmd_o    = '0;
    dec_cmd_o.op = host_link_pkg::opcode_t'(head.wr.opcode);
    case (head.wr.opcode)
      host_link_pkg::OP_WRITE: begin
        dec_cmd_o.addr = head.wr.addr;
        dec_cmd_o.tag  = head.wr.tag;
        dec_cmd_o.data = head.wr.data;
      end
      host_link_pkg::OP_READ, host_link_pkg::OP_NOP: begin
        dec_cmd_o.addr = head.rd.addr;
        dec_cmd_o.tag  = head.rd.tag;
      end
      default: begin
        // Unknown opcode, keep the tag for the error result
        dec_cmd_o.tag     = head.rd.tag;
        dec_cmd_o.illegal = 1'b1;
      end
    endcase
  end

  // Host must hold a credit for every command it sends
  assert property (@(posedge soc_clk) disable iff (!rst_n) cmd_valid_i |-> !full)
    else $error("cmd_decode: command arrived with the FIFO full");

endmodule

//--- logic/cmd_execute.sv
// Settings registers, command execution, result register and boot mode select
`timescale 1ns/1ps

module cmd_execute (
  input  logic                      soc_clk,
  input  logic                      rst_n,
  input  logic                      dec_valid_i,
  input  host_link_pkg::dec_cmd_t   dec_cmd_i,
  output logic                      exe_ready_o,
  input  logic                      res_space_i,
  output logic                      res_valid_o,
  output host_link_pkg::rsp_t       res_o,
  input  board_cfg_pkg::boot_mode_t boot_mode_i,
  output board_cfg_pkg::fan_duty_t  fan_duty_o,
  output logic                      sw_rst_o,
  output board_cfg_pkg::boot_mode_t boot_mode_o
);

  // Scratch value that requests a soft reset
  localparam logic [15:0] SwRstKey = 16'hdead;

  board_cfg_pkg::fan_duty_t duty_q;
  board_cfg_pkg::boot_ovr_t ovr_q;
  logic [15:0]              scratch_q;
  host_link_pkg::rsp_t      res_d;
  host_link_pkg::rsp_t      res_q;
  logic                     res_valid_q;
  logic                     sw_rst_q;
  logic                     wr_duty;
  logic                     wr_ovr;
  logic                     wr_scratch;

  assign exe_ready_o = res_space_i;
  assign boot_mode_o = ovr_q.en ? ovr_q.mode : boot_mode_i;

  ////////////////////////////////////////
  // Execute
  ////////////////////////////////////////

  always_comb begin
    res_d        = '0;
    res_d.tag    = dec_cmd_i.tag;
    res_d.status = host_link_pkg::ST_OK;
    wr_duty      = 1'b0;
    wr_ovr       = 1'b0;
    wr_scratch   = 1'b0;
    if (dec_cmd_i.illegal) begin
      res_d.status = host_link_pkg::ST_BAD_OP;
    end else if (dec_cmd_i.op == host_link_pkg::OP_WRITE) begin
      res_d.data = dec_cmd_i.data;
      case (dec_cmd_i.addr)
        board_cfg_pkg::REG_FAN_DUTY: wr_duty    = dec_valid_i;
        board_cfg_pkg::REG_BOOT_OVR: wr_ovr     = dec_valid_i;
        board_cfg_pkg::REG_SCRATCH:  wr_scratch = dec_valid_i;
        default: begin
          res_d.status = host_link_pkg::ST_BAD_ADDR;
          res_d.data   = '0;
        end
      endcase
    end else if (dec_cmd_i.op == host_link_pkg::OP_READ) begin
      case (dec_cmd_i.addr)
        board_cfg_pkg::REG_FAN_DUTY: res_d.data = {12'b0, duty_q};
        board_cfg_pkg::REG_BOOT_OVR: res_d.data = {13'b0, ovr_q};
        board_cfg_pkg::REG_BOOT_EFF: res_d.data = {14'b0, boot_mode_o};
        board_cfg_pkg::REG_SCRATCH:  res_d.data = scratch_q;
        default:                     res_d.status = host_link_pkg::ST_BAD_ADDR;
      endcase
    end
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      duty_q      <= '0;
      ovr_q       <= '0;
      scratch_q   <= '0;
      res_valid_q <= 1'b0;
      sw_rst_q    <= 1'b0;
    end else begin
      if (wr_duty) begin
        duty_q <= dec_cmd_i.data[3:0];
      end
      if (wr_ovr) begin
        ovr_q <= dec_cmd_i.data[2:0];
      end
      if (wr_scratch) begin
        scratch_q <= dec_cmd_i.data;
      end
      res_valid_q <= dec_valid_i;
      sw_rst_q    <= wr_scratch && (dec_cmd_i.data == SwRstKey);
    end
  end

  always_ff @(posedge soc_clk) begin
    if (dec_valid_i) begin
      res_q <= res_d;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;
  assign fan_duty_o  = duty_q;
  assign sw_rst_o    = sw_rst_q;

  // Decode only hands over a command when the result FIFO had room
  assert property (@(posedge soc_clk) disable iff (!rst_n) res_valid_o |-> $past(res_space_i))
    else $error("cmd_execute: result issued without result FIFO space");

endmodule

//--- logic/cmd_result.sv
// Result FIFO, response credit counter and registered response output
`timescale 1ns/1ps

module cmd_result #(
  parameter int unsigned RspDepth = 4
) (
  input  logic                soc_clk,
  input  logic                rst_n,
  input  logic                res_valid_i,
  input  host_link_pkg::rsp_t res_i,
  output logic                res_space_o,
  input  logic                rsp_credit_i,
  output logic                rsp_valid_o,
  output host_link_pkg::rsp_t rsp_o
);

  localparam int unsigned PtrW = (RspDepth > 1) ? $clog2(RspDepth) : 1;
  localparam int unsigned CntW = $clog2(RspDepth + 1);

  host_link_pkg::rsp_t mem_q [RspDepth];
  host_link_pkg::rsp_t rsp_q;
  logic [PtrW-1:0]     wr_ptr_q;
  logic [PtrW-1:0]     rd_ptr_q;
  logic [CntW-1:0]     count_q;
  logic [CntW-1:0]     credit_q;
  logic                rsp_valid_q;
  logic                full;
  logic                push;
  logic                send;

  assign full = (count_q == CntW'(RspDepth));
  assign push = res_valid_i && !full;
  // Head leaves only against a host credit
  assign send = (count_q != '0) && (credit_q != '0);

  // One slot for the result in the execute register, one for the next command
  assign res_space_o = (CntW'(RspDepth) - count_q) >= CntW'(2);

  always_ff @(posedge soc_clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= res_i;
    end
    if (send) begin
      rsp_q <= mem_q[rd_ptr_q];
    end
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      credit_q    <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(RspDepth - 1)) ? '0 : wr_ptr_q + PtrW'(1);
      end
      if (send) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(RspDepth - 1)) ? '0 : rd_ptr_q + PtrW'(1);
      end
      count_q     <= count_q + CntW'(push) - CntW'(send);
      credit_q    <= credit_q + CntW'(rsp_credit_i) - CntW'(send);
      rsp_valid_q <= send;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  // Host never grants more than the FIFO can hold
  assert property (@(posedge soc_clk) disable iff (!rst_n) credit_q <= CntW'(RspDepth))
    else $error("cmd_result: response credits exceed RspDepth");

  assert property (@(posedge soc_clk) disable iff (!rst_n) res_valid_i |-> !full)
    else $error("cmd_result: result arrived with the FIFO full");

endmodule

//--- logic/fan_pwm_gen.sv
// Sixteen-step fan PWM with duty latched at the period start
`timescale 1ns/1ps

module fan_pwm_gen (
  input  logic                     soc_clk,
  input  logic                     rst_n,
  input  board_cfg_pkg::fan_duty_t duty_i,
  output logic                     fan_pwm_o
);

  localparam logic [3:0] LastPhase = 4'(board_cfg_pkg::PwmSteps - 1);

  logic [3:0]               phase_q;
  logic [3:0]               phase_d;
  board_cfg_pkg::fan_duty_t duty_q;
  board_cfg_pkg::fan_duty_t duty_d;
  logic                     pwm_q;

  // Duty only changes when the next phase is zero
  always_comb begin
    phase_d = (phase_q == LastPhase) ? 4'd0 : phase_q + 4'd1;
    duty_d  = (phase_d == 4'd0) ? duty_i : duty_q;
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= '0;
      duty_q  <= '0;
      pwm_q   <= 1'b0;
    end else begin
      phase_q <= phase_d;
      duty_q  <= duty_d;
      pwm_q   <= (phase_d < duty_d);
    end
  end

  assign fan_pwm_o = pwm_q;

endmodule

//--- logic/board_ctrl_top.sv
// Board control top level with reset, command pipeline and fan PWM instances
`timescale 1ns/1ps

module board_ctrl_top #(
  parameter int unsigned CmdDepth = 4,
  parameter int unsigned RspDepth = 4,
  parameter int unsigned RtcDiv   = 50
) (
  input  logic                      soc_clk,
  input  logic                      sys_rst_ni,
  input  logic                      test_mode_i,
  input  board_cfg_pkg::boot_mode_t boot_mode_i,
  input  logic                      cmd_valid_i,
  input  host_link_pkg::cmd_word_u  cmd_i,
  output logic                      cmd_credit_o,
  input  logic                      rsp_credit_i,
  output logic                      rsp_valid_o,
  output host_link_pkg::rsp_t       rsp_o,
  output board_cfg_pkg::boot_mode_t boot_mode_o,
  output logic                      rtc_o,
  output logic                      fan_pwm_o
);

  logic                     rst_n;
  logic                     sw_rst;
  logic                     exe_ready;
  logic                     dec_valid;
  logic                     res_space;
  logic                     res_valid;
  host_link_pkg::dec_cmd_t  dec_cmd;
  host_link_pkg::rsp_t      res;
  board_cfg_pkg::fan_duty_t fan_duty;

  ////////////////////////////////////////
  // Clock and reset
  ////////////////////////////////////////

  clock_reset_unit #(
    .RtcDiv ( RtcDiv )
  ) i_clock_reset_unit (
    .soc_clk     ( soc_clk     ),
    .sys_rst_ni  ( sys_rst_ni  ),
    .sw_rst_i    ( sw_rst      ),
    .test_mode_i ( test_mode_i ),
    .rst_no      ( rst_n       ),
    .rtc_o       ( rtc_o       )
  );

  ////////////////////////////////////////
  // Command pipeline
  ////////////////////////////////////////

  cmd_decode #(
    .CmdDepth ( CmdDepth )
  ) i_cmd_decode (
    .soc_clk      ( soc_clk      ),
    .rst_n        ( rst_n        ),
    .cmd_valid_i  ( cmd_valid_i  ),
    .cmd_i        ( cmd_i        ),
    .cmd_credit_o ( cmd_credit_o ),
    .exe_ready_i  ( exe_ready    ),
    .dec_valid_o  ( dec_valid    ),
    .dec_cmd_o    ( dec_cmd      )
  );

  cmd_execute i_cmd_execute (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .dec_valid_i ( dec_valid   ),
    .dec_cmd_i   ( dec_cmd     ),
    .exe_ready_o ( exe_ready   ),
    .res_space_i ( res_space   ),
    .res_valid_o ( res_valid   ),
    .res_o       ( res         ),
    .boot_mode_i ( boot_mode_i ),
    .fan_duty_o  ( fan_duty    ),
    .sw_rst_o    ( sw_rst      ),
    .boot_mode_o ( boot_mode_o )
  );

  cmd_result #(
    .RspDepth ( RspDepth )
  ) i_cmd_result (
    .soc_clk      ( soc_clk      ),
    .rst_n        ( rst_n        ),
    .res_valid_i  ( res_valid    ),
    .res_i        ( res          ),
    .res_space_o  ( res_space    ),
    .rsp_credit_i ( rsp_credit_i ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_o        ( rsp_o        )
  );

  // Fan
  fan_pwm_gen i_fan_pwm_gen (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( rst_n     ),
    .duty_i    ( fan_duty  ),
    .fan_pwm_o ( fan_pwm_o )
  );

endmodule

//--- verification/board_ctrl_tb.sv
// Board control testbench with stimulus table, credit bookkeeping, RTC and PWM checks
`timescale 1ns/1ps

module board_ctrl_tb;

  localparam int unsigned CmdDepth = 4;
  localparam int unsigned RspDepth = 4;
  localparam int unsigned RtcDiv   = 50;
  localparam int          Timeout  = 1000;
  localparam logic [3:0]  FanDuty  = 4'd11;

  typedef struct {
    string                     name;
    host_link_pkg::cmd_word_u  cmd;
    board_cfg_pkg::boot_mode_t pins;
    host_link_pkg::rsp_t       exp;
    board_cfg_pkg::boot_mode_t boot;
  } test_t;

  logic                      soc_clk;
  logic                      sys_rst_ni;
  logic                      test_mode_i;
  board_cfg_pkg::boot_mode_t boot_mode_i;
  logic                      cmd_valid_i;
  host_link_pkg::cmd_word_u  cmd_i;
  logic                      cmd_credit_o;
  logic                      rsp_credit_i;
  logic                      rsp_valid_o;
  host_link_pkg::rsp_t       rsp_o;
  board_cfg_pkg::boot_mode_t boot_mode_o;
  logic                      rtc_o;
  logic                      fan_pwm_o;

  test_t               table_q[$];
  host_link_pkg::rsp_t got_q[$];
  int                  cmd_credits;
  int                  rsp_held;
  int                  err_count;
  int                  test_count;
  logic [31:0]         rng_state;
  logic [7:0]          next_tag;

  board_ctrl_top #(
    .CmdDepth ( CmdDepth ),
    .RspDepth ( RspDepth ),
    .RtcDiv   ( RtcDiv   )
  ) UUT (
    .soc_clk      ( soc_clk      ),
    .sys_rst_ni   ( sys_rst_ni   ),
    .test_mode_i  ( test_mode_i  ),
    .boot_mode_i  ( boot_mode_i  ),
    .cmd_valid_i  ( cmd_valid_i  ),
    .cmd_i        ( cmd_i        ),
    .cmd_credit_o ( cmd_credit_o ),
    .rsp_credit_i ( rsp_credit_i ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_o        ( rsp_o        ),
    .boot_mode_o  ( boot_mode_o  ),
    .rtc_o        ( rtc_o        ),
    .fan_pwm_o    ( fan_pwm_o    )
  );

  initial soc_clk = 1'b0;
  always #4 soc_clk = ~soc_clk;

  ////////////////////////////////////////
  // Link monitors
  ////////////////////////////////////////

  // Mid-cycle sampling of the one-cycle pulses
  always @(negedge soc_clk) begin
    if (cmd_credit_o) begin
      cmd_credits++;
    end
    if (rsp_valid_o) begin
      if (rsp_held == 0) begin
        $display("Response appeared without a granted credit");
        err_count++;
      end else begin
        rsp_held--;
      end
      got_q.push_back(rsp_o);
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Random scratch value, never the soft reset key
  function automatic logic [15:0] scratch_value();
    rng_state = xorshift(rng_state);
    return (rng_state[15:0] == 16'hdead) ? 16'h1234 : rng_state[15:0];
  endfunction

  function automatic host_link_pkg::rsp_t mk_rsp(input host_link_pkg::status_t st,
                                                 input logic [7:0] tag,
                                                 input logic [15:0] data);
    host_link_pkg::rsp_t r;
    r.status = st;
    r.tag    = tag;
    r.data   = data;
    return r;
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_rsp(input string name, input host_link_pkg::rsp_t exp,
                           input host_link_pkg::rsp_t act);
    if (act !== exp) begin
      $display("ERR %s expected st=%0d tag=%h data=%h actual st=%0d tag=%h data=%h",
               name, exp.status, exp.tag, exp.data, act.status, act.tag, act.data);
      err_count++;
    end
  endtask

  task automatic check_boot(input string name, input board_cfg_pkg::boot_mode_t exp,
                            input board_cfg_pkg::boot_mode_t act);
    if (act !== exp) begin
      $display("ERR %s expected boot=%b actual boot=%b", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act !== exp) begin
      $display("ERR %s expected %0d actual %0d", name, exp, act);
      err_count++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_count++;
    $display("%s %s", (err_count == errs_before) ? "ok  " : "fail", name);
  endtask

  ////////////////////////////////////////
  // Host link tasks
  ////////////////////////////////////////

  task automatic send_cmd(input host_link_pkg::cmd_word_u w);
    int waited;
    waited = 0;
    while (cmd_credits == 0 && waited < Timeout) begin
      @(posedge soc_clk);
      waited++;
    end
    if (cmd_credits == 0) begin
      $display("No command credit came back within %0d cycles", Timeout);
      err_count++;
    end else begin
      @(posedge soc_clk);
      cmd_valid_i <= 1'b1;
      cmd_i       <= w;
      cmd_credits--;
      @(posedge soc_clk);
      cmd_valid_i <= 1'b0;
    end
  endtask

  task automatic grant_credit();
    @(posedge soc_clk);
    rsp_credit_i <= 1'b1;
    rsp_held++;
    @(posedge soc_clk);
    rsp_credit_i <= 1'b0;
  endtask

  task automatic wait_rsp(input string name, output host_link_pkg::rsp_t r, output bit ok);
    int waited;
    waited = 0;
    r      = '0;
    ok     = 1'b0;
    while (got_q.size() == 0 && waited < Timeout) begin
      @(posedge soc_clk);
      waited++;
    end
    if (got_q.size() == 0) begin
      $display("%s got no response within %0d cycles", name, Timeout);
      err_count++;
    end else begin
      r  = got_q.pop_front();
      ok = 1'b1;
    end
  endtask

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  task automatic add_wr(input string name, input board_cfg_pkg::reg_addr_t addr,
                        input logic [15:0] data, input board_cfg_pkg::boot_mode_t pins,
                        input host_link_pkg::status_t st, input logic [15:0] exp_data,
                        input board_cfg_pkg::boot_mode_t boot);
    test_t t;
    t.name            = name;
    t.cmd.wr.opcode   = host_link_pkg::OP_WRITE;
    t.cmd.wr.addr     = addr;
    t.cmd.wr.data     = data;
    t.cmd.wr.tag      = next_tag;
    t.pins            = pins;
    t.exp             = mk_rsp(st, next_tag, exp_data);
    t.boot            = boot;
    table_q.push_back(t);
    next_tag++;
  endtask

  // Read view also carries NOP and unknown opcodes
  task automatic add_rd(input string name, input logic [3:0] op,
                        input board_cfg_pkg::reg_addr_t addr,
                        input board_cfg_pkg::boot_mode_t pins,
                        input host_link_pkg::status_t st, input logic [15:0] exp_data,
                        input board_cfg_pkg::boot_mode_t boot);
    test_t t;
    t.name          = name;
    t.cmd.rd.opcode = op;
    t.cmd.rd.addr   = addr;
    t.cmd.rd.tag    = next_tag;
    t.cmd.rd.pad    = '0;
    t.pins          = pins;
    t.exp           = mk_rsp(st, next_tag, exp_data);
    t.boot          = boot;
    table_q.push_back(t);
    next_tag++;
  endtask

  task automatic build_table();
    logic [15:0] scr;
    scr = scratch_value();
    add_wr("wr_duty_5", board_cfg_pkg::REG_FAN_DUTY, 16'd5, 2'b10, host_link_pkg::ST_OK,
           16'd5, 2'b10);
    add_rd("rd_duty_5", host_link_pkg::OP_READ, board_cfg_pkg::REG_FAN_DUTY, 2'b10,
           host_link_pkg::ST_OK, 16'd5, 2'b10);
    add_wr("wr_scratch", board_cfg_pkg::REG_SCRATCH, scr, 2'b10, host_link_pkg::ST_OK,
           scr, 2'b10);
    add_rd("rd_scratch", host_link_pkg::OP_READ, board_cfg_pkg::REG_SCRATCH, 2'b10,
           host_link_pkg::ST_OK, scr, 2'b10);
    add_rd("rd_boot_pins", host_link_pkg::OP_READ, board_cfg_pkg::REG_BOOT_EFF, 2'b10,
           host_link_pkg::ST_OK, 16'd2, 2'b10);
    add_rd("nop_new_pins", host_link_pkg::OP_NOP, 4'd0, 2'b11, host_link_pkg::ST_OK,
           16'd0, 2'b11);
    // Override on with mode 01
    add_wr("wr_boot_ovr", board_cfg_pkg::REG_BOOT_OVR, 16'h0005, 2'b11,
           host_link_pkg::ST_OK, 16'h0005, 2'b01);
    add_rd("rd_boot_ovr", host_link_pkg::OP_READ, board_cfg_pkg::REG_BOOT_OVR, 2'b11,
           host_link_pkg::ST_OK, 16'h0005, 2'b01);
    add_rd("rd_boot_eff", host_link_pkg::OP_READ, board_cfg_pkg::REG_BOOT_EFF, 2'b11,
           host_link_pkg::ST_OK, 16'd1, 2'b01);
    add_wr("wr_boot_eff", board_cfg_pkg::REG_BOOT_EFF, 16'h0003, 2'b11,
           host_link_pkg::ST_BAD_ADDR, 16'd0, 2'b01);
    add_rd("rd_bad_addr", host_link_pkg::OP_READ, 4'd9, 2'b11, host_link_pkg::ST_BAD_ADDR,
           16'd0, 2'b01);
    add_rd("bad_opcode", 4'hf, 4'd0, 2'b11, host_link_pkg::ST_BAD_OP, 16'd0, 2'b01);
    add_wr("ovr_off", board_cfg_pkg::REG_BOOT_OVR, 16'h0000, 2'b11, host_link_pkg::ST_OK,
           16'h0000, 2'b11);
    add_wr("wr_duty_11", board_cfg_pkg::REG_FAN_DUTY, 16'(FanDuty), 2'b11,
           host_link_pkg::ST_OK, 16'(FanDuty), 2'b11);
    add_rd("rd_duty_11", host_link_pkg::OP_READ, board_cfg_pkg::REG_FAN_DUTY, 2'b11,
           host_link_pkg::ST_OK, 16'(FanDuty), 2'b11);
  endtask

  ////////////////////////////////////////
  // Measurements
  ////////////////////////////////////////

  task automatic measure_pwm();
    int errs_before;
    int high;
    errs_before = err_count;
    // Two periods for the new duty to settle
    repeat (2 * board_cfg_pkg::PwmSteps) @(negedge soc_clk);
    for (int w = 0; w < 2; w++) begin
      high = 0;
      for (int i = 0; i < board_cfg_pkg::PwmSteps; i++) begin
        @(negedge soc_clk);
        high += int'(fan_pwm_o);
      end
      check_count("fan_pwm_high", int'(FanDuty), high);
    end
    end_test("fan_pwm", errs_before);
  endtask

  task automatic measure_rtc();
    int errs_before;
    int cycles;
    int waited;
    logic prev;
    errs_before = err_count;
    waited      = 0;
    cycles      = 0;
    prev        = rtc_o;
    // Align to a rising edge
    while (!(!prev && rtc_o) && waited < Timeout) begin
      prev = rtc_o;
      @(negedge soc_clk);
      waited++;
    end
    if (waited >= Timeout) begin
      $display("rtc_o did not rise within %0d cycles", Timeout);
      err_count++;
    end else begin
      prev = rtc_o;
      do begin
        prev = rtc_o;
        @(negedge soc_clk);
        cycles++;
      end while (!(!prev && rtc_o) && cycles < Timeout);
      check_count("rtc_period", int'(RtcDiv), cycles);
    end
    end_test("rtc_period", errs_before);
  endtask

  ////////////////////////////////////////
  // Back-pressure
  ////////////////////////////////////////

  task automatic run_backpressure();
    host_link_pkg::rsp_t      exp_q[$];
    host_link_pkg::rsp_t      r;
    host_link_pkg::cmd_word_u w;
    logic [15:0]              model_scratch;
    int                       errs_before;
    int                       granted;
    int                       waited;
    bit                       ok;
    errs_before   = err_count;
    model_scratch = '0;
    granted       = 0;
    waited        = 0;
    fork
      begin
        for (int i = 0; i < CmdDepth + RspDepth; i++) begin
          w = '0;
          if (i % 2 == 0) begin
            model_scratch = scratch_value();
            w.wr.opcode   = host_link_pkg::OP_WRITE;
            w.wr.addr     = board_cfg_pkg::REG_SCRATCH;
            w.wr.data     = model_scratch;
            w.wr.tag      = 8'h80 + 8'(i);
          end else begin
            w.rd.opcode = host_link_pkg::OP_READ;
            w.rd.addr   = board_cfg_pkg::REG_SCRATCH;
            w.rd.tag    = 8'h80 + 8'(i);
          end
          exp_q.push_back(mk_rsp(host_link_pkg::ST_OK, 8'h80 + 8'(i), model_scratch));
          send_cmd(w);
        end
      end
      begin
        // Response credits stay back until the host runs out of command credits
        while (cmd_credits != 0 && waited < Timeout) begin
          @(posedge soc_clk);
          waited++;
        end
        if (cmd_credits != 0) begin
          $display("Host never ran out of command credits while responses were held back");
          err_count++;
        end
        check_count("bp_no_early_rsp", 0, got_q.size());
        waited = 0;
        while (granted < CmdDepth + RspDepth && waited < Timeout) begin
          rng_state = xorshift(rng_state);
          repeat (rng_state[2:0]) @(posedge soc_clk);
          if (rsp_held < RspDepth) begin
            grant_credit();
            granted++;
          end else begin
            @(posedge soc_clk);
            waited++;
          end
        end
      end
    join
    while (exp_q.size() != 0) begin
      wait_rsp("backpressure", r, ok);
      if (ok) begin
        check_rsp("backpressure", exp_q.pop_front(), r);
      end else begin
        exp_q.delete();
      end
    end
    waited = 0;
    while (cmd_credits != CmdDepth && waited < Timeout) begin
      @(posedge soc_clk);
      waited++;
    end
    check_count("bp_credits_back", int'(CmdDepth), cmd_credits);
    end_test("backpressure", errs_before);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    host_link_pkg::rsp_t r;
    bit                  ok;
    int                  errs_before;
    sys_rst_ni   = 1'b0;
    test_mode_i  = 1'b0;
    boot_mode_i  = 2'b10;
    cmd_valid_i  = 1'b0;
    cmd_i        = '0;
    rsp_credit_i = 1'b0;
    cmd_credits  = CmdDepth;
    rsp_held     = 0;
    err_count    = 0;
    test_count   = 0;
    rng_state    = 32'hd637;
    next_tag     = 8'h10;

    repeat (5) @(posedge soc_clk);
    sys_rst_ni <= 1'b1;
    // Synchronizer releases two edges later
    repeat (3) @(posedge soc_clk);
    @(negedge soc_clk);
    errs_before = err_count;
    check_count("rst_cmd_credit", 0, int'(cmd_credit_o));
    check_count("rst_rsp_valid", 0, int'(rsp_valid_o));
    check_count("rst_fan_pwm", 0, int'(fan_pwm_o));
    check_boot("rst_boot", 2'b10, boot_mode_o);
    end_test("reset_state", errs_before);

    build_table();
    foreach (table_q[i]) begin
      errs_before = err_count;
      @(posedge soc_clk);
      boot_mode_i <= table_q[i].pins;
      grant_credit();
      send_cmd(table_q[i].cmd);
      wait_rsp(table_q[i].name, r, ok);
      if (ok) begin
        check_rsp(table_q[i].name, table_q[i].exp, r);
      end
      @(negedge soc_clk);
      check_boot(table_q[i].name, table_q[i].boot, boot_mode_o);
      end_test(table_q[i].name, errs_before);
    end

    measure_pwm();
    measure_rtc();
    run_backpressure();

    $display("tests=%0d errors=%0d", test_count, err_count);
    if (err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- all.f
logic/board_cfg_pkg.sv
logic/host_link_pkg.sv
logic/clock_reset_unit.sv
logic/cmd_decode.sv
logic/cmd_execute.sv
logic/cmd_result.sv
logic/fan_pwm_gen.sv
logic/board_ctrl_top.sv
verification/board_ctrl_tb.sv

//--- Bender.yml
package:
  name: board_ctrl

sources:
  # Packages first, then the blocks and the top level
  - logic/board_cfg_pkg.sv
  - logic/host_link_pkg.sv
  - logic/clock_reset_unit.sv
  - logic/cmd_decode.sv
  - logic/cmd_execute.sv
  - logic/cmd_result.sv
  - logic/fan_pwm_gen.sv
  - logic/board_ctrl_top.sv
  - target: test
    files:
      - verification/board_ctrl_tb.sv
